// ==== files.f ====
+incdir+src
+incdir+test
src/preBraInstrPkg.sv
src/preBraPredictPkg.sv
src/laneRedirectIf.sv
src/branchPredictor.sv
src/branchPreDecode.sv
src/branchSelect.sv
src/preBraTop.sv
test/tbPreBra.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -Wno-fatal --top-module tbPreBra -f files.f -o simPreBra \
	&& ./obj_dir/simPreBra | tee /dev/stderr | grep -qx "=== PASS ===" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }

// ==== test/preBraModel.svh ====
`ifndef PREBRA_MODEL_SVH
`define PREBRA_MODEL_SVH

// reference copy of the predictor table and history
preBraPredictPkg::predState refTable [2**`PREBRA_IDX_BITS];
logic [`PREBRA_IDX_BITS-1:0] refHistory;
// states read for the last fetched bundle
preBraPredictPkg::predState fetchStates [`PREBRA_LANES];

// expected registered outputs for the bundle now in decode
logic expValid;
logic [`PREBRA_PC_BITS-1:0] expPc;
logic [1:0] expLane;
logic [1:0] expKind;

function automatic void resetTable();
	refHistory = '0;
	foreach (refTable[i])
		refTable[i] = preBraPredictPkg::weakNotTaken;
endfunction

// eight-state walk for one resolved outcome
function automatic preBraPredictPkg::predState nextPredState(
	input logic taken,
	input preBraPredictPkg::predState s
);
	preBraPredictPkg::predState r;
	case (s)
		preBraPredictPkg::weakNotTaken:
			r = taken ? preBraPredictPkg::transWeakTaken : preBraPredictPkg::strongNotTaken;
		preBraPredictPkg::strongNotTaken:
			r = taken ? preBraPredictPkg::weakNotTaken : preBraPredictPkg::strongNotTaken;
		preBraPredictPkg::transWeakNotTaken:
			r = taken ? preBraPredictPkg::transStrongTaken : preBraPredictPkg::weakNotTaken;
		preBraPredictPkg::transStrongNotTaken:
			r = taken ? preBraPredictPkg::transStrongTaken : preBraPredictPkg::transWeakNotTaken;
		preBraPredictPkg::weakTaken:
			r = taken ? preBraPredictPkg::strongTaken : preBraPredictPkg::transWeakNotTaken;
		preBraPredictPkg::strongTaken:
			r = taken ? preBraPredictPkg::strongTaken : preBraPredictPkg::weakTaken;
		preBraPredictPkg::transWeakTaken:
			r = taken ? preBraPredictPkg::weakTaken : preBraPredictPkg::transStrongNotTaken;
		default:
			r = taken ? preBraPredictPkg::transWeakTaken : preBraPredictPkg::transStrongNotTaken;
	endcase
	return r;
endfunction

// execute report, index uses the history before the shift
function automatic void trainEntry(input logic [`PREBRA_PC_BITS-1:0] pc, input logic taken);
	logic [`PREBRA_IDX_BITS-1:0] idx;
	idx = pc[`PREBRA_IDX_BITS:1] ^ refHistory;
	refTable[idx] = nextPredState(taken, refTable[idx]);
	refHistory = {refHistory[`PREBRA_IDX_BITS-2:0], taken};
endfunction

// per-slot table read at fetch time
function automatic void readStates(input logic [`PREBRA_PC_BITS-1:0] pc);
	logic [`PREBRA_PC_BITS-1:0] lanePc;
	for (int lane = 0; lane < `PREBRA_LANES; lane++)
	begin
		lanePc = pc + `PREBRA_PC_BITS'(4 * lane);
		fetchStates[lane] = refTable[lanePc[`PREBRA_IDX_BITS:1] ^ refHistory];
	end
endfunction

// one slot, straight from the pre-decode rules
function automatic void decodeSlot(
	input logic [`PREBRA_PC_BITS-1:0] pc,
	input logic [31:0] w,
	input preBraPredictPkg::predState st,
	input logic [63:0] link,
	output logic hit,
	output logic [1:0] kind,
	output logic [`PREBRA_PC_BITS-1:0] target
);
	logic uncond;
	logic cond;
	logic isLong;
	logic ret;
	longint disp;
	longint low;
	ret = (w[15:0] == 16'h3012);
	isLong = (w[15:8] == 8'hF0) && (w[31:30] == 2'b11);
	uncond = (w[15:9] == 7'b0010000) || (isLong && !w[29]);
	cond = (w[15:9] == 7'b0010001) || (isLong && w[29]);
	// sign by hand, long displacement is bits 7..0 then 27..16
	if (isLong)
		disp = longint'({w[7:0], w[27:16]}) - (w[7] ? longint'(1 << 20) : 0);
	else
		disp = longint'(w[7:0]) - (w[7] ? 256 : 0);
	// low part has to stay inside its window, else no redirect
	low = longint'(pc[`PREBRA_ADD_BITS-1:0]) + 2 * disp;
	target = ret ? link[`PREBRA_PC_BITS-1:0] :
		{pc[`PREBRA_PC_BITS-1:`PREBRA_ADD_BITS], low[`PREBRA_ADD_BITS-1:0]};
	kind = ret ? preBraInstrPkg::kindReturn : uncond ? preBraInstrPkg::kindUncond :
		cond ? preBraInstrPkg::kindCond : preBraInstrPkg::kindNone;
	hit = ret || ((low >= 0) && (low < (longint'(1) << `PREBRA_ADD_BITS)) &&
		(uncond || (cond && (st[2] ^ st[1]))));
endfunction

// whole bundle, first redirecting slot wins
function automatic void predictBundle(
	input logic valid,
	input logic [`PREBRA_PC_BITS-1:0] pc,
	input logic [32*`PREBRA_LANES-1:0] words,
	input logic [63:0] link
);
	logic hit;
	logic [1:0] kind;
	logic [`PREBRA_PC_BITS-1:0] target;
	expValid = 1'b0;
	expPc = '0;
	expLane = '0;
	expKind = preBraInstrPkg::kindNone;
	for (int lane = 0; lane < `PREBRA_LANES; lane++)
	begin
		decodeSlot(pc + `PREBRA_PC_BITS'(4 * lane), words[32*lane +: 32],
			fetchStates[lane], link, hit, kind, target);
		if (valid && hit && !expValid)
		begin
			expValid = 1'b1;
			expPc = target;
			expLane = 2'(lane);
			expKind = kind;
		end
	end
endfunction

`endif

// ==== test/tbPreBra.sv ====
`timescale 1ns/100ps
`include "preBra_settings.svh"

module tbPreBra;

	localparam int ResetCycles = 8;
	localparam int IdleCycles = 20;
	localparam int RandomCycles = 800;
	// two more cycles drain the last bundle
	localparam int TestCycles = IdleCycles + RandomCycles + 2;
	localparam int TimeoutCycles = ResetCycles + TestCycles + 50;

	logic clock;
	logic rstN;
	logic fetchValid;
	logic [`PREBRA_PC_BITS-1:0] fetchPc;
	logic decodeValid;
	logic [32*`PREBRA_LANES-1:0] decodeWords;
	logic [63:0] linkValue;
	logic resolveValid;
	logic [`PREBRA_PC_BITS-1:0] resolvePc;
	logic resolveTaken;
	logic resolveCond;
	logic redirectValid;
	logic [`PREBRA_PC_BITS-1:0] redirectPc;
	logic [1:0] redirectLane;
	logic [1:0] redirectKind;

	// bundle fetched last cycle, decoded this cycle
	logic pendValid;
	logic [`PREBRA_PC_BITS-1:0] pendPc;
	logic [32*`PREBRA_LANES-1:0] pendWords;

	logic [31:0] lcgState;
	int cycleCount = 0;
	int checks;
	int errors;
	int redirects;

	`include "preBraModel.svh"

	preBraTop preBraTop_inst (.*);

	always #2 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount > TimeoutCycles)
		begin
			$display("timeout, run still going after %0d cycles", TimeoutCycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// low state bits are weak, so hand out the high half first
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return {lcgState[15:0], lcgState[31:16]};
	endfunction

	// branch forms, return, or anything else
	function automatic logic [31:0] makeSlot();
		logic [31:0] sel;
		logic [31:0] w;
		sel = nextRand();
		w = nextRand();
		case (sel % 6)
			0: w[15:9] = 7'b0010000;
			1: w[15:9] = 7'b0010001;
			2:
			begin
				w[31:29] = 3'b110;
				w[15:8] = 8'hF0;
			end
			3:
			begin
				w[31:29] = 3'b111;
				w[15:8] = 8'hF0;
			end
			4: w[15:0] = 16'h3012;
			default: ;
		endcase
		return w;
	endfunction

	// half the addresses sit at an edge of the 24-bit window to force carries
	function automatic logic [`PREBRA_PC_BITS-1:0] pickPc();
		logic [31:0] sel;
		logic [31:0] hi;
		logic [`PREBRA_PC_BITS-1:0] pc;
		sel = nextRand();
		hi = nextRand();
		pc = {hi[15:0], nextRand()};
		if (sel % 4 == 0)
			pc[23:8] = 16'hFFFF;
		else if (sel % 4 == 1)
			pc[23:8] = 16'h0000;
		pc[1:0] = 2'b00;
		return pc;
	endfunction

	task automatic checkOutputs();
		checks++;
		assert (redirectValid === expValid)
		else
		begin
			$display("Fail redirectValid got %h expected %h at cycle %0d",
				redirectValid, expValid, cycleCount);
			errors++;
		end
		assert (redirectKind === expKind)
		else
		begin
			$display("Fail redirectKind got %h expected %h at cycle %0d",
				redirectKind, expKind, cycleCount);
			errors++;
		end
		if (expValid && redirectValid)
		begin
			redirects++;
			assert (redirectPc === expPc)
			else
			begin
				$display("Fail redirectPc got %h expected %h at cycle %0d",
					redirectPc, expPc, cycleCount);
				errors++;
			end
			assert (redirectLane === expLane)
			else
			begin
				$display("Fail redirectLane got %h expected %h at cycle %0d",
					redirectLane, expLane, cycleCount);
				errors++;
			end
		end
	endtask

	task automatic driveCycle(input logic active);
		logic [31:0] r;
		// decode the bundle fetched one cycle ago
		decodeValid = pendValid;
		decodeWords = pendWords;
		r = nextRand();
		linkValue = {r, nextRand()};
		predictBundle(pendValid, pendPc, pendWords, linkValue);
		// new fetch, mostly back to back
		r = nextRand();
		fetchValid = active && (r % 8 != 0);
		if (fetchValid)
		begin
			fetchPc = pickPc();
			for (int lane = 0; lane < `PREBRA_LANES; lane++)
				pendWords[32*lane +: 32] = makeSlot();
			readStates(fetchPc);
		end
		pendValid = fetchValid;
		pendPc = fetchPc;
		// execute report lands on the same edge as the read above
		r = nextRand();
		resolveValid = active && r[0];
		resolveCond = (r[3:2] != 2'b00);
		resolveTaken = r[5];
		resolvePc = (r[8] ? pendPc : pickPc()) + `PREBRA_PC_BITS'(4 * r[10]);
		if (resolveValid && resolveCond)
			trainEntry(resolvePc, resolveTaken);
	endtask

	initial
	begin
		clock = 1'b0;
		rstN = 1'b0;
		fetchValid = 1'b0;
		fetchPc = '0;
		decodeValid = 1'b0;
		decodeWords = '0;
		linkValue = '0;
		resolveValid = 1'b0;
		resolvePc = '0;
		resolveTaken = 1'b0;
		resolveCond = 1'b0;
		pendValid = 1'b0;
		pendPc = '0;
		pendWords = '0;
		lcgState = 32'd90;
		checks = 0;
		errors = 0;
		redirects = 0;
		resetTable();
		predictBundle(1'b0, '0, '0, '0);
		repeat (ResetCycles) @(posedge clock);
		#1;
		rstN = 1'b1;
		// quiet stretch first, then random bundles
		for (int cyc = 0; cyc < TestCycles; cyc++)
		begin
			@(posedge clock);
			#1;
			checkOutputs();
			driveCycle((cyc >= IdleCycles) && (cyc < IdleCycles + RandomCycles));
		end
		$display("checks %0d, redirects %0d, errors %0d", checks, redirects, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== src/preBraTop.sv ====
`timescale 1ns/100ps
`include "preBra_settings.svh"

module preBraTop (
	input logic clock,
	input logic rstN,
	input logic fetchValid,
	input logic [`PREBRA_PC_BITS-1:0] fetchPc,
	input logic decodeValid,
	input logic [32*`PREBRA_LANES-1:0] decodeWords,
	input logic [63:0] linkValue,
	input logic resolveValid,
	input logic [`PREBRA_PC_BITS-1:0] resolvePc,
	input logic resolveTaken,
	input logic resolveCond,
	output logic redirectValid,
	output logic [`PREBRA_PC_BITS-1:0] redirectPc,
	output logic [1:0] redirectLane,
	output logic [1:0] redirectKind
);

	// fetch address held for the decode cycle
	logic [`PREBRA_PC_BITS-1:0] decodePc;
	preBraPredictPkg::resolvedBranch resolveBus;
	preBraPredictPkg::predState laneState [`PREBRA_LANES];
	preBraInstrPkg::redirectKind selKind;

	laneRedirectIf laneBus [`PREBRA_LANES] ();

	always_ff @(posedge clock)
	begin
		if (fetchValid)
			decodePc <= fetchPc;
	end

	// only valid conditional reports touch the predictor
	assign resolveBus = '{pc: resolvePc, cond: resolveValid && resolveCond,
		taken: resolveTaken};

	branchPredictor branchPredictor_inst (
		.clock(clock),
		.rstN(rstN),
		.fetchValid(fetchValid),
		.fetchPc(fetchPc),
		.resolve(resolveBus),
		.laneState(laneState)
	);

	// one pre-decoder per slot, slot g sits 4 bytes after slot g-1
	for (genvar g = 0; g < `PREBRA_LANES; g++)
	begin : gDecode
		branchPreDecode branchPreDecode_inst (
			.lanePc(decodePc + `PREBRA_PC_BITS'(4 * g)),
			.word(decodeWords[32*g +: 32]),
			.state(laneState[g]),
			.linkValue(linkValue),
			.decodeValid(decodeValid),
			.out(laneBus[g])
		);
	end

	branchSelect branchSelect_inst (
		.clock(clock),
		.rstN(rstN),
		.lanes(laneBus),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.redirectLane(redirectLane),
		.redirectKind(selKind)
	);

	// plain encoding at the boundary
	assign redirectKind = selKind;

endmodule

// ==== src/branchSelect.sv ====
`timescale 1ns/100ps
`include "preBra_settings.svh"

module branchSelect (
	input logic clock,
	input logic rstN,
	laneRedirectIf.sink lanes [`PREBRA_LANES],
	output logic redirectValid,
	output logic [`PREBRA_PC_BITS-1:0] redirectPc,
	// two bits cover up to four lanes
	output logic [1:0] redirectLane,
	output preBraInstrPkg::redirectKind redirectKind
);

	logic [`PREBRA_LANES-1:0] laneHit;
	logic [`PREBRA_PC_BITS-1:0] laneTarget [`PREBRA_LANES];
	preBraInstrPkg::redirectKind laneKind [`PREBRA_LANES];
	logic pickValid;
	logic [`PREBRA_PC_BITS-1:0] pickPc;
	logic [1:0] pickLane;
	preBraInstrPkg::redirectKind pickKind;

	// flatten the lane buses, merge the conditional flag into the kind
	for (genvar g = 0; g < `PREBRA_LANES; g++)
	begin : gLane
		assign laneHit[g] = lanes[g].redirect;
		assign laneTarget[g] = lanes[g].target;
		assign laneKind[g] = lanes[g].isCond ? preBraInstrPkg::kindCond : lanes[g].kind;
	end

	// walk down so the lowest redirecting lane wins
	always_comb
	begin
		pickValid = 1'b0;
		pickPc = laneTarget[0];
		pickLane = 2'd0;
		pickKind = preBraInstrPkg::kindNone;
		for (int i = `PREBRA_LANES - 1; i >= 0; i--)
		begin
			if (laneHit[i])
			begin
				pickValid = 1'b1;
				pickPc = laneTarget[i];
				pickLane = 2'(i);
				pickKind = laneKind[i];
			end
		end
	end

	// strobe and kind
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			redirectValid <= 1'b0;
			redirectKind <= preBraInstrPkg::kindNone;
		end
		else
		begin
			redirectValid <= pickValid;
			redirectKind <= pickKind;
		end
	end

	// target and lane, only meaningful with the strobe
	always_ff @(posedge clock)
	begin
		redirectPc <= pickPc;
		redirectLane <= pickLane;
	end

endmodule

// ==== src/branchPreDecode.sv ====
`timescale 1ns/100ps
`include "preBra_settings.svh"

module branchPreDecode (
	input logic [`PREBRA_PC_BITS-1:0] lanePc,
	input preBraInstrPkg::slotWord word,
	input preBraPredictPkg::predState state,
	input logic [63:0] linkValue,
	input logic decodeValid,
	laneRedirectIf.source out
);

	logic isBraShort;
	logic isBraLong;
	logic isCcShort;
	logic isCcLong;
	logic isLongBase;
	logic isReturn;
	logic isUncond;
	logic isCond;
	logic predictTaken;
	logic [`PREBRA_ADD_BITS-1:0] dispShort;
	logic [`PREBRA_ADD_BITS-1:0] dispLong;
	logic [`PREBRA_ADD_BITS-1:0] disp;
	// one extra bit for the carry out
	logic [`PREBRA_ADD_BITS:0] sum;
	logic [`PREBRA_PC_BITS-1:0] braTarget;

	// short forms, major 2
	assign isBraShort = (word.shortForm.major == 4'h2) && (word.shortForm.subOp == 3'b000);
	assign isCcShort = (word.shortForm.major == 4'h2) && (word.shortForm.subOp == 3'b001);

	// long forms, major F with zero nibble
	assign isLongBase = (word.longForm.major == 4'hF) && (word.longForm.zero == 4'h0);
	assign isBraLong = isLongBase && (word.longForm.subOp == 3'b110);
	assign isCcLong = isLongBase && (word.longForm.subOp == 3'b111);

	// return from subroutine, whole low half
	assign isReturn = ({word.shortForm.major, word.shortForm.subOp,
		word.shortForm.spare, word.shortForm.disp} == 16'h3012);

	assign isUncond = isBraShort || isBraLong;
	assign isCond = isCcShort || isCcLong;

	// transitional not-taken states also predict taken
	assign predictTaken = state[2] ^ state[1];

	// sign extend both displacements to the add width
	assign dispShort = {{(`PREBRA_ADD_BITS - 8){word.shortForm.disp[7]}},
		word.shortForm.disp};
	assign dispLong = {{(`PREBRA_ADD_BITS - 20){word.longForm.dispHigh[7]}},
		word.longForm.dispHigh, word.longForm.dispLow};
	assign disp = (isBraLong || isCcLong) ? dispLong : dispShort;

	// halfword displacement, low part only
	assign sum = {1'b0, lanePc[`PREBRA_ADD_BITS-1:0]} + {disp, 1'b0};

	// upper address bits pass unchanged
	assign braTarget = {lanePc[`PREBRA_PC_BITS-1:`PREBRA_ADD_BITS],
		sum[`PREBRA_ADD_BITS-1:0]};

	// return target comes straight from the link value
	assign out.target = isReturn ? linkValue[`PREBRA_PC_BITS-1:0] : braTarget;

	// carry out means the upper bits would change, too slow here
	assign out.redirect = decodeValid && (isReturn ||
		((isUncond || (isCond && predictTaken)) && !sum[`PREBRA_ADD_BITS]));

	// conditional class is marked separately
	assign out.kind = isReturn ? preBraInstrPkg::kindReturn :
		isUncond ? preBraInstrPkg::kindUncond : preBraInstrPkg::kindNone;
	assign out.isCond = isCond;

endmodule

// ==== src/branchPredictor.sv ====
`timescale 1ns/100ps
`include "preBra_settings.svh"

module branchPredictor (
	input logic clock,
	input logic rstN,
	input logic fetchValid,
	input logic [`PREBRA_PC_BITS-1:0] fetchPc,
	input preBraPredictPkg::resolvedBranch resolve,
	output preBraPredictPkg::predState laneState [`PREBRA_LANES]
);

	// state table, one entry per history-hashed index
	preBraPredictPkg::predState stateTable [2**`PREBRA_IDX_BITS];
	// global history, newest outcome in bit 0
	logic [`PREBRA_IDX_BITS-1:0] history;

	logic [`PREBRA_PC_BITS-1:0] lanePc [`PREBRA_LANES];
	logic [`PREBRA_IDX_BITS-1:0] readIdx [`PREBRA_LANES];
	logic [`PREBRA_IDX_BITS-1:0] updIdx;

	// transition rule, indexed by outcome and current state
	function automatic preBraPredictPkg::predState nextState(
		input logic taken,
		input preBraPredictPkg::predState cur
	);
		preBraPredictPkg::predState nxt;
		case ({taken, cur})
			// not taken
			4'b0000: nxt = preBraPredictPkg::strongNotTaken;
			4'b0001: nxt = preBraPredictPkg::strongNotTaken;
			4'b0010: nxt = preBraPredictPkg::weakNotTaken;
			4'b0011: nxt = preBraPredictPkg::transWeakNotTaken;
			4'b0100: nxt = preBraPredictPkg::transWeakNotTaken;
			4'b0101: nxt = preBraPredictPkg::weakTaken;
			4'b0110: nxt = preBraPredictPkg::transStrongNotTaken;
			4'b0111: nxt = preBraPredictPkg::transStrongNotTaken;
			// taken
			4'b1000: nxt = preBraPredictPkg::transWeakTaken;
			4'b1001: nxt = preBraPredictPkg::weakNotTaken;
			4'b1010: nxt = preBraPredictPkg::transStrongTaken;
			4'b1011: nxt = preBraPredictPkg::transStrongTaken;
			4'b1100: nxt = preBraPredictPkg::strongTaken;
			4'b1101: nxt = preBraPredictPkg::strongTaken;
			4'b1110: nxt = preBraPredictPkg::weakTaken;
			default: nxt = preBraPredictPkg::transWeakTaken;
		endcase
		return nxt;
	endfunction

	// per-lane read index, slot address hashed with history
	always_comb
	begin
		for (int lane = 0; lane < `PREBRA_LANES; lane++)
		begin
			lanePc[lane] = fetchPc + `PREBRA_PC_BITS'(4 * lane);
			readIdx[lane] = lanePc[lane][`PREBRA_IDX_BITS:1] ^ history;
		end
	end

	// update index uses history before this report shifts in
	assign updIdx = resolve.pc[`PREBRA_IDX_BITS:1] ^ history;

	// table and history, written by execute reports
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			history <= '0;
			for (int i = 0; i < 2**`PREBRA_IDX_BITS; i++)
				stateTable[i] <= preBraPredictPkg::weakNotTaken;
		end
		else if (resolve.cond)
		begin
			history <= {history[`PREBRA_IDX_BITS-2:0], resolve.taken};
			stateTable[updIdx] <= nextState(resolve.taken, stateTable[updIdx]);
		end
	end

	// read stage, a same-edge update is not seen here
	always_ff @(posedge clock)
	begin
		if (fetchValid)
		begin
			for (int lane = 0; lane < `PREBRA_LANES; lane++)
				laneState[lane] <= stateTable[readIdx[lane]];
		end
	end

endmodule

// ==== src/laneRedirectIf.sv ====
`timescale 1ns/100ps
`include "preBra_settings.svh"

// one lane's early redirect decision
interface laneRedirectIf;

	// lane wants to redirect fetch
	logic redirect;
	// slot class, uncond or return, none otherwise
	preBraInstrPkg::redirectKind kind;
	// redirect target address
	logic [`PREBRA_PC_BITS-1:0] target;
	// slot holds a conditional branch
	logic isCond;

	// lane side
	modport source (output redirect, output kind, output target, output isCond);

	// selector side
	modport sink (input redirect, input kind, input target, input isCond);

endinterface

// ==== src/preBraPredictPkg.sv ====
`include "preBra_settings.svh"

package preBraPredictPkg;

	// eight-state branch predictor
	// taken is predicted when bit 2 xor bit 1 is set
	typedef enum logic [2:0] {
		weakNotTaken = 3'b000,
		strongNotTaken = 3'b001,
		transWeakNotTaken = 3'b010,
		transStrongNotTaken = 3'b011,
		weakTaken = 3'b100,
		strongTaken = 3'b101,
		transWeakTaken = 3'b110,
		transStrongTaken = 3'b111
	} predState;

	// outcome of a branch from execute
	// cond only set for a valid conditional report
	typedef struct packed {
		logic [`PREBRA_PC_BITS-1:0] pc;
		logic cond;
		logic taken;
	} resolvedBranch;

endpackage

// ==== src/preBraInstrPkg.sv ====
package preBraInstrPkg;

	// short form, everything decoded sits in the low half
	typedef struct packed {
		logic [15:0] upperHalf;
		logic [3:0] major;
		logic [2:0] subOp;
		logic spare;
		logic [7:0] disp;
	} shortSlot;

	// long form, displacement split around the opcode nibbles
	typedef struct packed {
		logic [2:0] subOp;
		logic spare;
		// low 12 bits of the 20-bit displacement
		logic [11:0] dispLow;
		logic [3:0] major;
		logic [3:0] zero;
		// top 8 bits of the displacement, bit 7 is the sign
		logic [7:0] dispHigh;
	} longSlot;

	// one 32-bit slot, read either way
	typedef union packed {
		shortSlot shortForm;
		longSlot longForm;
	} slotWord;

	// what kind of early redirect was taken
	typedef enum logic [1:0] {
		kindNone = 2'd0,
		kindUncond = 2'd1,
		kindCond = 2'd2,
		kindReturn = 2'd3
	} redirectKind;

endpackage

// ==== src/preBra_settings.svh ====
`ifndef PREBRA_SETTINGS_SVH
`define PREBRA_SETTINGS_SVH

// instruction slots per fetch bundle, 1 to 4
`define PREBRA_LANES 2

// predictor table index and global history width
`define PREBRA_IDX_BITS 6

// instruction address width
`define PREBRA_PC_BITS 48

// low part of the target add, carry out of it blocks the redirect
`define PREBRA_ADD_BITS 24

`endif
